// File: logic/uartPkg.sv
`default_nettype none

package uartPkg;

	// register index, taken from adr[3:2]
	localparam logic [1:0] RegData = 2'd0;	// tx push on write, rx pop on read
	localparam logic [1:0] RegStat = 2'd1;	// read only
	localparam logic [1:0] RegCmd  = 2'd2;
	localparam logic [1:0] RegCtrl = 2'd3;	// word length + divisor

	localparam int WordLenW = 4;
	localparam int DivW = 16;	// divisor lives in ctrl[31:16]

	// command register bits, parity code in 7:5 with bit 5 as enable
	localparam int CmdRxIeBit = 0;
	localparam int CmdTxIeBit = 1;
	localparam int CmdLoopBit = 4;

	// codes as seen in cmd[7:5]
	typedef enum logic [2:0] {
		parNone  = 3'b000,
		parOdd   = 3'b001,
		parEven  = 3'b011,
		parMark  = 3'b101,	// forced 1
		parSpace = 3'b111	// forced 0
	} ParityE;

	typedef struct packed {
		logic [7:0] data;
		logic parityErr;
		logic frameErr;
	} RxEntryT;

	// status word bit positions
	localparam int statRxAvail   = 0;
	localparam int statTxEmpty   = 1;
	localparam int statTxFull    = 2;
	localparam int statParityErr = 3;	// flags of rx head entry
	localparam int statFrameErr  = 4;
	localparam int statIrq       = 5;

	// parity bit for the frame, acc is xor of all data bits
	function automatic logic parityBit(input ParityE par, input logic acc);
		case (par)
			parOdd:  return ~acc;
			parEven: return acc;
			parMark: return 1'b1;
			default: return 1'b0;	// space
		endcase
	endfunction

endpackage

`default_nettype wire

// File: logic/uartFifo.sv
`timescale 1ns/1ps
`default_nettype none

module uartFifo #(
	parameter type PayloadT = logic [7:0],
	parameter int Depth = 8
) (
	input  logic    clk_i,
	input  logic    rst_i,
	input  logic    push_i,
	input  PayloadT din_i,
	input  logic    pop_i,
	output PayloadT dout_o,
	output logic    empty_o,
	output logic    full_o
);

	localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CntW = $clog2(Depth + 1);

	PayloadT mem [Depth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;	// entries held
	logic doPush;
	logic doPop;

	// wrap by compare so Depth need not be a power of two
	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
		return (p == PtrW'(Depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign doPush = push_i & ~full_o;	// drop when full
	assign doPop = pop_i & ~empty_o;
	assign empty_o = (count == '0);
	assign full_o = (count == CntW'(Depth));
	assign dout_o = mem[rdPtr];	// head always visible

	always_ff @(posedge clk_i) begin
		if (doPush)
			mem[wrPtr] <= din_i;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			if (doPush & ~doPop)
				count <= count + 1'b1;
			else if (doPop & ~doPush)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: logic/uartRegDecode.sv
`timescale 1ns/1ps
`default_nettype none

module uartRegDecode import uartPkg::*; #(
	parameter logic [DivW-1:0] ResetDiv = 16'd27
) (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                cyc_i,
	input  logic                stb_i,
	input  logic                we_i,
	input  logic [3:2]          adr_i,
	input  logic [31:0]         dat_i,
	output logic                ack_o,
	output logic                txPush_o,
	output logic [7:0]          txByte_o,
	output logic                rxPop_o,
	output logic [1:0]          rdSel_o,
	output logic                rdStrobe_o,
	output logic [WordLenW-1:0] wordLen_o,
	output ParityE              parity_o,
	output logic                loopback_o,
	output logic                rxIe_o,
	output logic                txIe_o,
	output logic [DivW-1:0]     divisor_o,
	output logic [31:0]         cmd_o,
	output logic [31:0]         ctrl_o
);

	logic req;	// new request, not yet acked
	logic wrReq;
	logic rdReq;
	logic popPend;	// data read waiting for its ack cycle
	logic [31:0] cmdReg;
	logic [31:0] ctrlReg;

	// ------------------------------------------------------------------
	// wishbone classic handshake
	// ------------------------------------------------------------------
	assign req = cyc_i & stb_i & ~ack_o;
	assign wrReq = req & we_i;
	assign rdReq = req & ~we_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o <= 1'b0;
			popPend <= 1'b0;
		end else begin
			ack_o <= req;	// single cycle, never stalls
			popPend <= rdReq & (adr_i == RegData);
		end
	end

	// strobes toward fifos and read mux
	assign txPush_o = wrReq & (adr_i == RegData);	// fifo drops it if full
	assign txByte_o = dat_i[7:0];
	assign rxPop_o = popPend;	// pop lands on the ack cycle
	assign rdStrobe_o = rdReq;
	assign rdSel_o = adr_i;

	// ------------------------------------------------------------------
	// command and control registers
	// ------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cmdReg <= '0;	// irqs off, no loopback, no parity
			ctrlReg <= {ResetDiv, 16'h0000};	// 8 bit words
		end else if (wrReq) begin
			if (adr_i == RegCmd)
				cmdReg <= dat_i;
			else if (adr_i == RegCtrl)
				ctrlReg <= dat_i;
		end
	end

	assign rxIe_o = cmdReg[CmdRxIeBit];
	assign txIe_o = cmdReg[CmdTxIeBit];
	assign loopback_o = cmdReg[CmdLoopBit];
	// bit 5 clear means no parity whatever 7:6 hold
	assign parity_o = cmdReg[5] ? ParityE'(cmdReg[7:5]) : parNone;

	// 00=8 01=7 10=6 11=5
	assign wordLen_o = WordLenW'(8) - WordLenW'(ctrlReg[6:5]);
	assign divisor_o = ctrlReg[31:16];

	assign cmd_o = cmdReg;	// raw words for readback
	assign ctrl_o = ctrlReg;

endmodule

`default_nettype wire

// File: logic/uartBaudGen.sv
`timescale 1ns/1ps
`default_nettype none

module uartBaudGen import uartPkg::*; (
	input  logic            clk_i,
	input  logic            rst_i,
	input  logic [DivW-1:0] divisor_i,
	output logic            tick_o
);

	logic [DivW-1:0] cnt;
	logic [DivW:0] cntNext;	// one bit wider, no wrap at max divisor

	assign cntNext = {1'b0, cnt} + 1'b1;

	// divisor of 0 or 1 ticks every clock
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			cnt <= '0;
			tick_o <= 1'b0;
		end else if (cntNext >= {1'b0, divisor_i}) begin
			cnt <= '0;
			tick_o <= 1'b1;	// 16x bit rate
		end else begin
			cnt <= cntNext[DivW-1:0];
			tick_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: logic/uartTx.sv
`timescale 1ns/1ps
`default_nettype none

module uartTx import uartPkg::*; (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                tick_i,
	input  logic [7:0]          byte_i,
	input  logic                fifoEmpty_i,
	input  logic [WordLenW-1:0] wordLen_i,
	input  ParityE              parity_i,
	input  logic                loopback_i,
	output logic                pop_o,
	output logic                txd_o,
	output logic                txLine_o,
	output logic                busy_o
);

	typedef enum logic [2:0] {TxIdle, TxStart, TxData, TxParity, TxStop} TxStateE;

	TxStateE state;
	logic [3:0] tickCnt;	// 16 ticks per bit
	logic [WordLenW-1:0] bitCnt;
	logic [7:0] shiftReg;
	logic parAcc;	// running xor of data bits sent
	logic txLine;
	logic bitDone;
	logic lastBit;

	assign pop_o = (state == TxIdle) & tick_i & ~fifoEmpty_i;	// start on a tick
	assign bitDone = tick_i & (tickCnt == 4'd15);
	assign lastBit = (bitCnt == WordLenW'(wordLen_i - 1'b1));
	assign busy_o = (state != TxIdle);
	assign txLine_o = txLine;
	assign txd_o = loopback_i ? 1'b1 : txLine;	// pin parked while looped back

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= TxIdle;
			tickCnt <= '0;
			bitCnt <= '0;
			txLine <= 1'b1;
		end else begin
			if (tick_i)
				tickCnt <= tickCnt + 4'd1;
			case (state)
				TxIdle: if (pop_o) begin
					state <= TxStart;
					tickCnt <= '0;
					txLine <= 1'b0;	// start bit
				end
				TxStart: if (bitDone) begin
					state <= TxData;
					bitCnt <= '0;
					txLine <= shiftReg[0];	// lsb first
				end
				TxData: if (bitDone) begin
					if (!lastBit) begin
						bitCnt <= bitCnt + 1'b1;
						txLine <= shiftReg[1];
					end else if (parity_i == parNone) begin
						state <= TxStop;
						txLine <= 1'b1;
					end else begin
						state <= TxParity;
						txLine <= parityBit(parity_i, parAcc);
					end
				end
				TxParity: if (bitDone) begin
					state <= TxStop;
					txLine <= 1'b1;
				end
				TxStop: if (bitDone)
					state <= TxIdle;	// line stays high
				default: state <= TxIdle;
			endcase
		end
	end

	// data path, byte loaded at pop and shifted per bit
	always_ff @(posedge clk_i) begin
		if (pop_o)
			shiftReg <= byte_i;
		else if ((state == TxData) && bitDone)
			shiftReg <= shiftReg >> 1;
		if ((state == TxStart) && bitDone)
			parAcc <= shiftReg[0];
		else if ((state == TxData) && bitDone && !lastBit)
			parAcc <= parAcc ^ shiftReg[1];
	end

endmodule

`default_nettype wire

// File: logic/uartRx.sv
`timescale 1ns/1ps
`default_nettype none

module uartRx import uartPkg::*; (
	input  logic                clk_i,
	input  logic                rst_i,
	input  logic                tick_i,
	input  logic                rxd_i,
	input  logic                txLine_i,
	input  logic                loopback_i,
	input  logic [WordLenW-1:0] wordLen_i,
	input  ParityE              parity_i,
	output logic                push_o,
	output RxEntryT             entry_o
);

	typedef enum logic [2:0] {RxIdle, RxStart, RxData, RxParity, RxStop} RxStateE;

	RxStateE state;
	logic [1:0] rxSync;	// two flop synchronizer
	logic rxPrev;	// for start edge
	logic rxLine;
	logic [3:0] tickCnt;
	logic [WordLenW-1:0] bitCnt;
	logic [7:0] shiftReg;	// fills from the top
	logic parAcc;
	logic parErr;
	logic midBit;	// tick 8 of the bit
	logic endBit;

	assign rxLine = rxSync[1];
	assign midBit = tick_i & (tickCnt == 4'd7);
	assign endBit = tick_i & (tickCnt == 4'd15);

	// ------------------------------------------------------------------
	// line select and sync
	// ------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rxSync <= 2'b11;	// idle high
			rxPrev <= 1'b1;
		end else begin
			rxSync <= {rxSync[0], loopback_i ? txLine_i : rxd_i};
			rxPrev <= rxLine;
		end
	end

	// ------------------------------------------------------------------
	// frame FSM
	// ------------------------------------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= RxIdle;
			tickCnt <= '0;
			bitCnt <= '0;
			push_o <= 1'b0;
		end else begin
			push_o <= 1'b0;
			if (tick_i)
				tickCnt <= tickCnt + 4'd1;
			case (state)
				RxIdle: if (rxPrev & ~rxLine) begin	// falling edge
					state <= RxStart;
					tickCnt <= '0;
				end
				RxStart: begin
					if (midBit & rxLine)
						state <= RxIdle;	// glitch, not a start bit
					else if (endBit) begin
						state <= RxData;
						bitCnt <= '0;
					end
				end
				RxData: if (endBit) begin
					if (bitCnt == WordLenW'(wordLen_i - 1'b1))
						state <= (parity_i == parNone) ? RxStop : RxParity;
					else
						bitCnt <= bitCnt + 1'b1;
				end
				RxParity: if (endBit)
					state <= RxStop;
				RxStop: if (midBit) begin
					state <= RxIdle;	// early exit, resync on next edge
					push_o <= 1'b1;
				end
				default: state <= RxIdle;
			endcase
		end
	end

	// samples, parity check and the finished entry
	always_ff @(posedge clk_i) begin
		if (state == RxStart) begin
			parAcc <= 1'b0;
			parErr <= 1'b0;
		end
		if (midBit) begin
			case (state)
				RxData: begin
					shiftReg <= {rxLine, shiftReg[7:1]};
					parAcc <= parAcc ^ rxLine;
				end
				RxParity: parErr <= (rxLine != parityBit(parity_i, parAcc));
				RxStop: begin
					entry_o.data <= shiftReg >> (WordLenW'(8) - wordLen_i);	// right align
					entry_o.parityErr <= parErr;
					entry_o.frameErr <= ~rxLine;	// stop bit read low
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/uartReadMux.sv
`timescale 1ns/1ps
`default_nettype none

module uartReadMux import uartPkg::*; (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic [1:0]  rdSel_i,
	input  logic        rdStrobe_i,
	input  RxEntryT     rxEntry_i,	// rx fifo head
	input  logic        rxEmpty_i,
	input  logic        txEmpty_i,
	input  logic        txBusy_i,
	input  logic        txFull_i,
	input  logic        rxIe_i,
	input  logic        txIe_i,
	input  logic [31:0] cmd_i,
	input  logic [31:0] ctrl_i,
	output logic [31:0] dat_o,
	output logic        irq_o
);

	logic txIdle;	// nothing queued, nothing on the line
	logic irqNext;
	logic [31:0] statWord;

	assign txIdle = txEmpty_i & ~txBusy_i;
	assign irqNext = (rxIe_i & ~rxEmpty_i) | (txIe_i & txIdle);	// level irq

	always_comb begin
		statWord = '0;
		statWord[statRxAvail] = ~rxEmpty_i;
		statWord[statTxEmpty] = txIdle;
		statWord[statTxFull] = txFull_i;
		statWord[statParityErr] = ~rxEmpty_i & rxEntry_i.parityErr;
		statWord[statFrameErr] = ~rxEmpty_i & rxEntry_i.frameErr;
		statWord[statIrq] = irq_o;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			irq_o <= 1'b0;
		else
			irq_o <= irqNext;
	end

	// captured on the request cycle, valid with ack
	always_ff @(posedge clk_i) begin
		if (rdStrobe_i) begin
			case (rdSel_i)
				RegData: dat_o <= {24'h000000, rxEntry_i.data};
				RegStat: dat_o <= statWord;
				RegCmd:  dat_o <= cmd_i;
				default: dat_o <= ctrl_i;	// RegCtrl
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/uartTop.sv
`timescale 1ns/1ps
`default_nettype none

module uartTop import uartPkg::*; #(
	parameter int FifoDepth = 8,
	parameter logic [DivW-1:0] ResetDiv = 16'd27
) (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [3:0]  adr_i,	// word addressed, 1:0 not decoded
	input  logic [31:0] dat_i,
	input  logic [3:0]  sel_i,	// full word access only, lanes not decoded
	output logic [31:0] dat_o,
	output logic        ack_o,
	input  logic        rxd_i,
	output logic        txd_o,
	output logic        irq_o
);

	logic txPush, rxPop, rdStrobe, loopback, rxIe, txIe;
	logic [7:0] txByte;
	logic [7:0] txHead;
	logic [1:0] rdSel;
	logic [WordLenW-1:0] wordLen;
	ParityE parity;
	logic [DivW-1:0] divisor;
	logic [31:0] cmdWord, ctrlWord;
	logic baudTick;
	logic txEmpty, txFull, txPop, txBusy, txLine;
	logic rxPush, rxEmpty;
	RxEntryT rxEntryIn, rxHead;

	uartRegDecode #(.ResetDiv(ResetDiv)) regDec0 (
		.clk_i, .rst_i, .cyc_i, .stb_i, .we_i, .adr_i(adr_i[3:2]), .dat_i, .ack_o,
		.txPush_o(txPush), .txByte_o(txByte), .rxPop_o(rxPop), .rdSel_o(rdSel),
		.rdStrobe_o(rdStrobe), .wordLen_o(wordLen), .parity_o(parity),
		.loopback_o(loopback), .rxIe_o(rxIe), .txIe_o(txIe), .divisor_o(divisor),
		.cmd_o(cmdWord), .ctrl_o(ctrlWord)
	);

	uartBaudGen baud0 (.clk_i, .rst_i, .divisor_i(divisor), .tick_o(baudTick));

	// ------------------------------------------------------------------
	// transmit side
	// ------------------------------------------------------------------
	uartFifo #(.PayloadT(logic [7:0]), .Depth(FifoDepth)) txFifo0 (
		.clk_i, .rst_i, .push_i(txPush), .din_i(txByte), .pop_i(txPop),
		.dout_o(txHead), .empty_o(txEmpty), .full_o(txFull)
	);

	uartTx tx0 (
		.clk_i, .rst_i, .tick_i(baudTick), .byte_i(txHead), .fifoEmpty_i(txEmpty),
		.wordLen_i(wordLen), .parity_i(parity), .loopback_i(loopback),
		.pop_o(txPop), .txd_o, .txLine_o(txLine), .busy_o(txBusy)
	);

	// ------------------------------------------------------------------
	// receive side, overflow entries are lost in the fifo
	// ------------------------------------------------------------------
	uartRx rx0 (
		.clk_i, .rst_i, .tick_i(baudTick), .rxd_i, .txLine_i(txLine),
		.loopback_i(loopback), .wordLen_i(wordLen), .parity_i(parity),
		.push_o(rxPush), .entry_o(rxEntryIn)
	);

	uartFifo #(.PayloadT(RxEntryT), .Depth(FifoDepth)) rxFifo0 (
		.clk_i, .rst_i, .push_i(rxPush), .din_i(rxEntryIn), .pop_i(rxPop),
		.dout_o(rxHead), .empty_o(rxEmpty), .full_o()
	);

	uartReadMux rdMux0 (
		.clk_i, .rst_i, .rdSel_i(rdSel), .rdStrobe_i(rdStrobe), .rxEntry_i(rxHead),
		.rxEmpty_i(rxEmpty), .txEmpty_i(txEmpty), .txBusy_i(txBusy), .txFull_i(txFull),
		.rxIe_i(rxIe), .txIe_i(txIe), .cmd_i(cmdWord), .ctrl_i(ctrlWord),
		.dat_o, .irq_o
	);

endmodule

`default_nettype wire

// File: dv/uartTb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module uartTb_asserts (
	input  logic clk_i,
	input  logic rst_i,
	input  logic cyc_i,
	input  logic stb_i,
	input  logic ack_i,
	input  logic txd_i,
	input  logic irq_i,
	input  logic loopback_i,
	input  logic rxIe_i,
	input  logic txIe_i,
	input  logic rxEmpty_i,
	input  logic txEmpty_i,
	input  logic txBusy_i
);

	int failCount = 0;	// read by the testbench at the end
	logic req;
	logic irqExpect;

	assign req = cyc_i & stb_i & ~ack_i;	// new wishbone request
	// level irq, rx data present or transmitter fully idle
	assign irqExpect = (rxIe_i & ~rxEmpty_i) | (txIe_i & txEmpty_i & ~txBusy_i);

	// ------------------------------------------------------------------
	// wishbone classic handshake
	// ------------------------------------------------------------------
	ackFollowsReq: assert property (@(posedge clk_i) disable iff (rst_i)
		req |=> ack_i)
	else begin
		failCount = failCount + 1;
		$error("ack_o did not follow a request by one cycle");
	end

	ackSingleCycle: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_i |=> !ack_i)
	else begin
		failCount = failCount + 1;
		$error("ack_o stayed high longer than one cycle");
	end

	ackHasReq: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_i |-> $past(req))
	else begin
		failCount = failCount + 1;
		$error("ack_o rose without a request in the cycle before");
	end

	ackNeedsCyc: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_i |-> cyc_i)
	else begin
		failCount = failCount + 1;
		$error("ack_o high while cyc_i was low");
	end

	// ------------------------------------------------------------------
	// serial pin and interrupt
	// ------------------------------------------------------------------
	loopTxdHigh: assert property (@(posedge clk_i) disable iff (rst_i)
		loopback_i |-> txd_i)	// pin parked during loopback
	else begin
		failCount = failCount + 1;
		$error("txd_o went low while loopback was set");
	end

	irqRule: assert property (@(posedge clk_i) disable iff (rst_i)
		irq_i == $past(irqExpect))	// registered, one cycle late
	else begin
		failCount = failCount + 1;
		$error("irq_o does not match the enabled interrupt sources");
	end

endmodule

bind uartTop uartTb_asserts asserts0 (
	.clk_i, .rst_i, .cyc_i, .stb_i, .ack_i(ack_o), .txd_i(txd_o), .irq_i(irq_o),
	.loopback_i(loopback), .rxIe_i(rxIe), .txIe_i(txIe), .rxEmpty_i(rxEmpty),
	.txEmpty_i(txEmpty), .txBusy_i(txBusy)
);

`default_nettype wire

// File: dv/uartTb.sv
`timescale 1ns/1ps
`default_nettype none

module uartTb import uartPkg::*; ();

	localparam int FifoDepth = 8;
	localparam logic [15:0] ResetDiv = 16'd27;
	localparam int TestDiv = 4;	// fast baud for the serial tests
	localparam int BitCycles = 16 * TestDiv;
	localparam int FrameBits = 11;	// start, 8 data, parity, stop
	localparam int NumFrames = 20;	// 8 + 4 + 4 + 2 + 1 + 1 over all tests
	localparam int WatchdogNs = 2 * NumFrames * FrameBits * BitCycles * 10 + 5000;
	localparam int AckLimit = 8;
	localparam logic [31:0] LoopCmd = 32'h1 << CmdLoopBit;
	localparam logic [31:0] FlagMask = (32'h1 << statRxAvail) | (32'h1 << statParityErr) |
		(32'h1 << statFrameErr);

	logic clk_i;
	logic rst_i;
	logic cyc_i;
	logic stb_i;
	logic we_i;
	logic [3:0] adr_i;
	logic [31:0] dat_i;
	logic [3:0] sel_i;
	logic [31:0] dat_o;
	logic ack_o;
	logic rxd_i;
	logic txd_o;
	logic irq_o;

	integer seed;
	int errCount = 0;
	int testErrStart = 0;
	int testsRun = 0;
	int testsFailed = 0;
	string curTest = "reset";

	uartTop #(.FifoDepth(FifoDepth), .ResetDiv(ResetDiv)) dut0 (
		.clk_i, .rst_i, .cyc_i, .stb_i, .we_i, .adr_i, .dat_i, .sel_i, .dat_o, .ack_o,
		.rxd_i, .txd_o, .irq_o
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	initial begin
		#(WatchdogNs);
		$display("watchdog expired after %0d ns, the tests did not finish", WatchdogNs);
		$display("Done: errors found");
		$finish;
	end

	// ------------------------------------------------------------------
	// expected words, built from the register map
	// ------------------------------------------------------------------
	function automatic logic [31:0] ctrlWord(input logic [15:0] div, input int bits);
		logic [1:0] lenCode;
		lenCode = 2'(8 - bits);	// 8/7/6/5 coded 0..3
		return {div, 9'b0, lenCode, 5'b0};
	endfunction

	function automatic logic [31:0] parCmd(input ParityE par);
		return {24'h0, par, 5'b0};	// code in cmd[7:5]
	endfunction

	function automatic logic [31:0] rxFlags(input logic avail, input logic parErr,
		input logic frmErr);
		logic [31:0] w;
		w = '0;
		w[statRxAvail] = avail;
		w[statParityErr] = parErr;
		w[statFrameErr] = frmErr;
		return w;
	endfunction

	task automatic checkVal(input string what, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (expVal !== actVal) begin
			$display("CHECK FAILED %s, %s: expected 0x%08h, actual 0x%08h", curTest, what,
				expVal, actVal);
			errCount++;
		end
	endtask

	task automatic reportError(input string msg);
		$display("ERROR in %s: %s", curTest, msg);
		errCount++;
	endtask

	task automatic beginTest(input string name);
		curTest = name;
		testErrStart = errCount;
	endtask

	task automatic endTest();
		testsRun++;
		if (errCount == testErrStart) begin
			$display("test %s: ok", curTest);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", curTest, errCount - testErrStart);
		end
	endtask

	// ------------------------------------------------------------------
	// wishbone master
	// ------------------------------------------------------------------
	task automatic busCycle(input logic write, input logic [1:0] regIdx,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int waitCnt;
		logic ackSeen;
		waitCnt = 0;
		ackSeen = 1'b0;
		rdata = '0;
		@(posedge clk_i);
		#1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i = write;
		adr_i = {regIdx, 2'b00};
		dat_i = wdata;
		while (!ackSeen && waitCnt < AckLimit) begin
			@(posedge clk_i);
			#1;
			waitCnt++;
			if (ack_o) begin
				ackSeen = 1'b1;
				rdata = dat_o;	// valid in the ack cycle
			end
		end
		if (!ackSeen)
			reportError("bus access was never acknowledged");
		@(posedge clk_i);	// hold cyc through the ack cycle
		#1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
	endtask

	task automatic wbWrite(input logic [1:0] regIdx, input logic [31:0] wdata);
		logic [31:0] unused;
		busCycle(1'b1, regIdx, wdata, unused);
	endtask

	task automatic wbRead(input logic [1:0] regIdx, output logic [31:0] rdata);
		busCycle(1'b0, regIdx, 32'h0, rdata);
	endtask

	task automatic waitStatus(input int bitIdx, input logic val, input int maxReads,
		input string what);
		logic [31:0] stat;
		int reads;
		reads = 0;
		wbRead(RegStat, stat);
		while (stat[bitIdx] !== val && reads < maxReads) begin
			wbRead(RegStat, stat);
			reads++;
		end
		if (stat[bitIdx] !== val)
			reportError({what, " did not happen in time"});
	endtask

	task automatic waitIrq(input logic val, input int maxCycles, input string what);
		int n;
		n = 0;
		while (irq_o !== val && n < maxCycles) begin
			@(posedge clk_i);
			#1;
			n++;
		end
		if (irq_o !== val)
			reportError({what, ", irq_o stayed at the wrong level"});
	endtask

	// ------------------------------------------------------------------
	// serial driver on rxd_i
	// ------------------------------------------------------------------
	task automatic driveBit(input logic v);
		@(posedge clk_i);
		#1;
		rxd_i = v;
		repeat (BitCycles - 1) @(posedge clk_i);
	endtask

	task automatic sendFrame(input logic [7:0] data, input logic withPar, input logic parBit,
		input logic stopBit);
		int i;
		driveBit(1'b0);	// start
		for (i = 0; i < 8; i++)
			driveBit(data[i]);	// lsb first
		if (withPar)
			driveBit(parBit);
		driveBit(stopBit);
		driveBit(1'b1);	// idle gap, also ends a low stop bit
	endtask

	// one 8N1 frame off the txd_o pin, sampled mid-bit
	task automatic captureFrame(output logic [7:0] data, output logic stopBit);
		int n;
		int i;
		n = 0;
		data = '0;
		stopBit = 1'b0;
		while (txd_o !== 1'b0 && n < 4 * BitCycles) begin
			@(posedge clk_i);
			#1;
			n++;
		end
		if (txd_o !== 1'b0) begin
			reportError("no start bit seen on txd_o");
		end else begin
			repeat (BitCycles / 2) @(posedge clk_i);	// middle of start bit
			#1;
			for (i = 0; i < 8; i++) begin
				repeat (BitCycles) @(posedge clk_i);
				#1;
				data[i] = txd_o;	// lsb first
			end
			repeat (BitCycles) @(posedge clk_i);
			#1;
			stopBit = txd_o;
		end
	endtask

	// bytes through the loopback path, returned in order with clean flags
	task automatic runLoopback(input string name, input logic [31:0] cmdW,
		input logic [31:0] ctrlW, input int nBytes, input logic [7:0] mask);
		logic [7:0] expQ[$];
		logic [7:0] b;
		logic [31:0] rd;
		int i;
		beginTest(name);
		wbWrite(RegCtrl, ctrlW);
		wbWrite(RegCmd, cmdW);
		for (i = 0; i < nBytes; i++) begin
			b = 8'($random(seed));
			wbWrite(RegData, {24'h0, b});
			expQ.push_back(b & mask);	// upper bits never sent
		end
		waitStatus(statTxEmpty, 1'b1, nBytes * FrameBits * BitCycles / 2, "transmitter drain");
		for (i = 0; i < nBytes; i++) begin
			wbRead(RegStat, rd);
			checkVal("status before pop", rxFlags(1'b1, 1'b0, 1'b0), rd & FlagMask);
			wbRead(RegData, rd);
			checkVal("rx data", {24'h0, expQ.pop_front()}, rd);
		end
		wbRead(RegStat, rd);
		checkVal("rx fifo empty", rxFlags(1'b0, 1'b0, 1'b0), rd & FlagMask);
		endTest();
	endtask

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------
	initial begin
		logic [31:0] rd;
		logic [7:0] b1;
		logic [7:0] b2;
		logic pinStop;
		int i;
		seed = 32'hf32;
		rst_i = 1'b1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		adr_i = '0;
		dat_i = '0;
		sel_i = 4'hf;	// full word only
		rxd_i = 1'b1;	// line idle
		repeat (16) @(posedge clk_i);
		#1;
		rst_i = 1'b0;

		beginTest("register readback");
		wbRead(RegCmd, rd);
		checkVal("cmd reset", 32'h0, rd);
		wbRead(RegCtrl, rd);
		checkVal("ctrl reset", ctrlWord(ResetDiv, 8), rd);
		wbRead(RegStat, rd);
		checkVal("status reset", 32'h1 << statTxEmpty, rd);
		wbWrite(RegCmd, 32'h000000a3);	// both irqs, mark parity
		wbRead(RegCmd, rd);
		checkVal("cmd write", 32'h000000a3, rd);
		wbWrite(RegCtrl, ctrlWord(16'h1234, 6));
		wbRead(RegCtrl, rd);
		checkVal("ctrl write", ctrlWord(16'h1234, 6), rd);
		wbWrite(RegCmd, 32'h0);
		endTest();

		runLoopback("loopback 8N1", LoopCmd, ctrlWord(TestDiv, 8), 8, 8'hff);
		runLoopback("loopback 7E1", LoopCmd | parCmd(parEven), ctrlWord(TestDiv, 7), 4, 8'h7f);
		runLoopback("loopback 7O1", LoopCmd | parCmd(parOdd), ctrlWord(TestDiv, 7), 4, 8'h7f);

		beginTest("parity and frame errors");
		wbWrite(RegCtrl, ctrlWord(TestDiv, 8));
		wbWrite(RegCmd, parCmd(parEven));	// external line
		b1 = 8'($random(seed));
		b2 = 8'($random(seed));
		sendFrame(b1, 1'b1, ~(^b1), 1'b1);	// even parity bit inverted
		sendFrame(b2, 1'b1, ^b2, 1'b0);	// good parity, stop bit low
		waitStatus(statRxAvail, 1'b1, 4, "rx data present");
		wbRead(RegStat, rd);
		checkVal("status frame 1", rxFlags(1'b1, 1'b1, 1'b0), rd & FlagMask);
		wbRead(RegData, rd);
		checkVal("data frame 1", {24'h0, b1}, rd);
		wbRead(RegStat, rd);
		checkVal("status frame 2", rxFlags(1'b1, 1'b0, 1'b1), rd & FlagMask);
		wbRead(RegData, rd);
		checkVal("data frame 2", {24'h0, b2}, rd);
		wbRead(RegStat, rd);
		checkVal("rx fifo empty", rxFlags(1'b0, 1'b0, 1'b0), rd & FlagMask);
		endTest();

		beginTest("interrupts");
		wbWrite(RegCmd, 32'h1 << CmdTxIeBit);	// tx idle source only
		waitIrq(1'b1, 8, "irq with tx idle");
		wbRead(RegStat, rd);
		checkVal("status irq bit", 32'h1 << statIrq, rd & (32'h1 << statIrq));
		wbWrite(RegCmd, 32'h1 << CmdRxIeBit);	// rx source only, 8N1
		waitIrq(1'b0, 8, "irq with rx fifo empty");
		b1 = 8'($random(seed));
		sendFrame(b1, 1'b0, 1'b0, 1'b1);
		waitIrq(1'b1, 2 * BitCycles, "irq on received frame");
		wbRead(RegData, rd);
		checkVal("rx data", {24'h0, b1}, rd);
		waitIrq(1'b0, 8, "irq after rx fifo read empty");
		endTest();

		beginTest("txd pin 8N1");
		wbWrite(RegCmd, 32'h0);	// loopback off, frame goes to the pin
		b1 = 8'($random(seed));
		wbWrite(RegData, {24'h0, b1});
		captureFrame(b2, pinStop);
		checkVal("txd data", {24'h0, b1}, {24'h0, b2});
		checkVal("txd stop bit", 32'h1, {31'h0, pinStop});
		waitStatus(statTxEmpty, 1'b1, BitCycles, "pin frame end");
		endTest();

		beginTest("tx fifo overflow");
		wbWrite(RegCmd, 32'h0);
		wbWrite(RegCtrl, ctrlWord(16'hffff, 8));	// slowest baud, fifo backs up
		for (i = 0; i < FifoDepth + 2; i++)
			wbWrite(RegData, {24'h0, 8'($random(seed))});
		wbRead(RegStat, rd);
		checkVal("tx full flag", 32'h1 << statTxFull, rd & (32'h1 << statTxFull));
		endTest();

		$display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
			testsRun, testsFailed, errCount, dut0.asserts0.failCount);
		if (errCount == 0 && dut0.asserts0.failCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
logic/uartPkg.sv
logic/uartFifo.sv
logic/uartRegDecode.sv
logic/uartBaudGen.sv
logic/uartTx.sv
logic/uartRx.sv
logic/uartReadMux.sv
logic/uartTop.sv
dv/uartTb_asserts.sv
dv/uartTb.sv

// File: Bender.yml
package:
  name: uart6551

sources:
  - logic/uartPkg.sv
  - logic/uartFifo.sv
  - logic/uartRegDecode.sv
  - logic/uartBaudGen.sv
  - logic/uartTx.sv
  - logic/uartRx.sv
  - logic/uartReadMux.sv
  - logic/uartTop.sv
  - target: simulation
    files:
      - dv/uartTb_asserts.sv
      - dv/uartTb.sv
